// ==== rtl/z80_dp_pkg.sv ====
`default_nettype none

package z80_dp_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int byte_w    = 8;
  localparam int word_w    = 16;

  // register file geometry, twelve bytes in six pairs
  localparam int num_regs     = 12;
  localparam int reg_idx_w    = 4;
  // only b to l carry a shadow copy
  localparam int num_ctx_regs = 6;

  // byte indices, high byte of a pair at the even slot
  localparam logic [reg_idx_w-1:0] reg_b   = 'd0;
  localparam logic [reg_idx_w-1:0] reg_c   = 'd1;
  localparam logic [reg_idx_w-1:0] reg_d   = 'd2;
  localparam logic [reg_idx_w-1:0] reg_e   = 'd3;
  localparam logic [reg_idx_w-1:0] reg_h   = 'd4;
  localparam logic [reg_idx_w-1:0] reg_l   = 'd5;
  localparam logic [reg_idx_w-1:0] reg_ixh = 'd6;
  localparam logic [reg_idx_w-1:0] reg_ixl = 'd7;
  localparam logic [reg_idx_w-1:0] reg_sph = 'd8;
  localparam logic [reg_idx_w-1:0] reg_spl = 'd9;
  localparam logic [reg_idx_w-1:0] reg_pch = 'd10;
  localparam logic [reg_idx_w-1:0] reg_pcl = 'd11;

  // pair n covers bytes 2n and 2n+1
  localparam int pair_w = 3;
  localparam logic [pair_w-1:0] pair_bc = 'd0;
  localparam logic [pair_w-1:0] pair_de = 'd1;
  localparam logic [pair_w-1:0] pair_hl = 'd2;
  localparam logic [pair_w-1:0] pair_ix = 'd3;
  localparam logic [pair_w-1:0] pair_sp = 'd4;
  localparam logic [pair_w-1:0] pair_pc = 'd5;

  // --------------------------------------------------
  // bus source codes
  // --------------------------------------------------
  localparam int data_src_w = 3;
  localparam logic [data_src_w-1:0] src_none = 'd0;
  localparam logic [data_src_w-1:0] src_reg  = 'd1;
  localparam logic [data_src_w-1:0] src_a    = 'd2;
  localparam logic [data_src_w-1:0] src_f    = 'd3;
  localparam logic [data_src_w-1:0] src_temp = 'd4;
  localparam logic [data_src_w-1:0] src_mdr1 = 'd5;
  localparam logic [data_src_w-1:0] src_mdr2 = 'd6;
  localparam logic [data_src_w-1:0] src_alu8 = 'd7;

  localparam int addr_src_w = 2;
  localparam logic [addr_src_w-1:0] asrc_none  = 'd0;
  localparam logic [addr_src_w-1:0] asrc_mar   = 'd1;
  localparam logic [addr_src_w-1:0] asrc_alu16 = 'd2;

  // one 16 bit pair, seen whole or as hi and lo bytes
  typedef union packed {
    logic [word_w-1:0] word;
    struct packed {
      logic [byte_w-1:0] hi;
      logic [byte_w-1:0] lo;
    } bytes;
  } reg_pair_u;

endpackage

`default_nettype wire

// ==== rtl/z80_alu_pkg.sv ====
`default_nettype none

package z80_alu_pkg;

  // --------------------------------------------------
  // alu operation codes
  // --------------------------------------------------
  localparam int alu_op_w = 4;
  // anything not listed below passes a
  localparam logic [alu_op_w-1:0] op_pass_a   = 'd0;
  localparam logic [alu_op_w-1:0] op_incr_a   = 'd1;
  localparam logic [alu_op_w-1:0] op_decr_a   = 'd2;
  localparam logic [alu_op_w-1:0] op_add      = 'd3;
  localparam logic [alu_op_w-1:0] op_pass_b   = 'd4;
  // a plus low byte of b sign extended, relative jumps and index offsets
  localparam logic [alu_op_w-1:0] op_add_se_b = 'd5;

  // --------------------------------------------------
  // flag bit positions in f
  // --------------------------------------------------
  localparam int flag_s  = 7;
  localparam int flag_z  = 6;
  localparam int flag_h  = 4;
  localparam int flag_pv = 2;
  localparam int flag_n  = 1;
  localparam int flag_c  = 0;

  // per flag override, 2'b0x leaves the flag alone
  localparam int flag_ctl_w = 2;
  localparam logic [flag_ctl_w-1:0] flag_set = 'd3;
  localparam logic [flag_ctl_w-1:0] flag_clr = 'd2;

endpackage

`default_nettype wire

// ==== rtl/z80_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_regfile (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [z80_dp_pkg::byte_w-1:0]    data_bus,
  input  logic [z80_dp_pkg::word_w-1:0]    addr_bus,
  input  logic [z80_dp_pkg::num_regs-1:0]  reg_ld,
  input  logic                             switch_context,
  input  logic [z80_dp_pkg::reg_idx_w-1:0] reg_sel,
  input  logic [z80_dp_pkg::pair_w-1:0]    pair_sel,
  output logic [z80_dp_pkg::byte_w-1:0]    reg_byte,
  output logic [z80_dp_pkg::word_w-1:0]    reg_pair
);
  import z80_dp_pkg::*;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  // main set, indexed as in the package
  logic [byte_w-1:0]     regs   [num_regs];
  // alternate b' c' d' e' h' l'
  logic [byte_w-1:0]     shadow [num_ctx_regs];
  // both bytes of pair p flagged for load
  logic [num_regs/2-1:0] pair_ld;
  reg_pair_u             addr_word;
  reg_pair_u             pair_rd;

  // split the address bus word into hi and lo
  assign addr_word.word = addr_bus;

  always_comb begin
    for (int p = 0; p < num_regs / 2; p++) begin
      pair_ld[p] = reg_ld[2*p] & reg_ld[2*p+1];
    end
  end

  // --------------------------------------------------
  // load and context trade
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < num_ctx_regs; i++) begin
        shadow[i] <= '0;
      end
    end else if (switch_context) begin
      // reg_ld picks which of b..l trade places with the shadow
      // index and sp/pc bytes hold during a switch
      for (int i = 0; i < num_ctx_regs; i++) begin
        if (reg_ld[i]) begin
          regs[i]   <= shadow[i];
          shadow[i] <= regs[i];
        end
      end
    end else begin
      for (int p = 0; p < num_regs / 2; p++) begin
        if (pair_ld[p]) begin
          // full pair write from the address side
          regs[2*p]   <= addr_word.bytes.hi;
          regs[2*p+1] <= addr_word.bytes.lo;
        end else begin
          // single bytes come off the data bus
          if (reg_ld[2*p]) begin
            regs[2*p] <= data_bus;
          end
          if (reg_ld[2*p+1]) begin
            regs[2*p+1] <= data_bus;
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // read ports
  // --------------------------------------------------
  // byte read for the data bus, out of range reads zero
  always_comb begin
    reg_byte = '0;
    if (reg_sel < reg_idx_w'(num_regs)) begin
      reg_byte = regs[reg_sel];
    end
  end

  // pair read into the 16 bit alu, independent of the byte read
  always_comb begin
    pair_rd.word = '0;
    if (pair_sel <= pair_pc) begin
      pair_rd.bytes.hi = regs[{pair_sel, 1'b0}];
      pair_rd.bytes.lo = regs[{pair_sel, 1'b1}];
    end
  end

  assign reg_pair = pair_rd.word;

endmodule

`default_nettype wire

// ==== rtl/z80_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_alu #(
  parameter int width = 8
) (
  input  logic [width-1:0]                 a,
  input  logic [width-1:0]                 b,
  input  logic [z80_alu_pkg::alu_op_w-1:0] op,
  input  logic [z80_dp_pkg::byte_w-1:0]    f_in,
  output logic [width-1:0]                 c,
  output logic [z80_dp_pkg::byte_w-1:0]    f_out
);
  import z80_dp_pkg::*;
  import z80_alu_pkg::*;

  // low byte of b as a signed offset
  logic signed [byte_w-1:0] b_lo;
  // offset widened to the alu width
  logic [width-1:0]         b_se;

  assign b_lo = b[byte_w-1:0];
  // signed cast widens with the sign bit
  assign b_se = width'(b_lo);

  // --------------------------------------------------
  // operation select
  // --------------------------------------------------
  always_comb begin
    // flags pass through unless an op says otherwise
    f_out = f_in;
    case (op)
      op_incr_a: begin
        c = a + width'(1);
      end
      op_decr_a: begin
        c = a - width'(1);
        // pv marks a counter that has not reached zero yet
        f_out[flag_pv] = (c != '0);
      end
      op_add: begin
        c = a + b;
      end
      op_pass_b: begin
        c = b;
      end
      op_add_se_b: begin
        c = a + b_se;
      end
      op_pass_a: begin
        c = a;
      end
      default: begin
        c = a;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/z80_acc_flags.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_acc_flags (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [z80_dp_pkg::byte_w-1:0]      data_bus,
  input  logic                               ld_a,
  input  logic                               ld_f_alu8,
  input  logic                               ld_f_alu16,
  input  logic [z80_dp_pkg::byte_w-1:0]      flags_alu8,
  input  logic [z80_dp_pkg::byte_w-1:0]      flags_alu16,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_s,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_z,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_h,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_pv,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_n,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_c,
  output logic [z80_dp_pkg::byte_w-1:0]      a_q,
  output logic [z80_dp_pkg::byte_w-1:0]      f_q
);
  import z80_dp_pkg::*;
  import z80_alu_pkg::*;

  logic [byte_w-1:0] f_d;
  logic              ovr_active;
  logic              f_en;

  // force one bit from its override code
  function automatic logic flag_apply(input logic cur, input logic [flag_ctl_w-1:0] ctl);
    case (ctl)
      flag_set: return 1'b1;
      flag_clr: return 1'b0;
      default:  return cur;
    endcase
  endfunction

  function automatic logic flag_forced(input logic [flag_ctl_w-1:0] ctl);
    return (ctl == flag_set) || (ctl == flag_clr);
  endfunction

  // --------------------------------------------------
  // next f
  // --------------------------------------------------
  always_comb begin
    // 8 bit alu wins over the 16 bit one
    if (ld_f_alu8) begin
      f_d = flags_alu8;
    end else if (ld_f_alu16) begin
      f_d = flags_alu16;
    end else begin
      f_d = f_q;
    end
    // overrides sit on top of whichever source was picked
    f_d[flag_s]  = flag_apply(f_d[flag_s], set_s);
    f_d[flag_z]  = flag_apply(f_d[flag_z], set_z);
    f_d[flag_h]  = flag_apply(f_d[flag_h], set_h);
    f_d[flag_pv] = flag_apply(f_d[flag_pv], set_pv);
    f_d[flag_n]  = flag_apply(f_d[flag_n], set_n);
    f_d[flag_c]  = flag_apply(f_d[flag_c], set_c);
  end

  assign ovr_active = flag_forced(set_s) | flag_forced(set_z) | flag_forced(set_h)
                    | flag_forced(set_pv) | flag_forced(set_n) | flag_forced(set_c);
  assign f_en       = ld_f_alu8 | ld_f_alu16 | ovr_active;

  // --------------------------------------------------
  // a and f registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q <= '0;
      f_q <= '0;
    end else begin
      if (ld_a) begin
        a_q <= data_bus;
      end
      if (f_en) begin
        f_q <= f_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/z80_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_datapath (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic [z80_dp_pkg::byte_w-1:0]      data_in,
  input  logic [z80_dp_pkg::num_regs-1:0]    reg_ld,
  input  logic [z80_dp_pkg::reg_idx_w-1:0]   reg_sel,
  input  logic [z80_dp_pkg::pair_w-1:0]      pair_sel,
  input  logic                               switch_context,
  input  logic                               ld_a,
  input  logic                               ld_f_alu8,
  input  logic                               ld_f_alu16,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_s,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_z,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_h,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_pv,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_n,
  input  logic [z80_alu_pkg::flag_ctl_w-1:0] set_c,
  input  logic [z80_alu_pkg::alu_op_w-1:0]   alu_op,
  input  logic [z80_dp_pkg::data_src_w-1:0]  data_src,
  input  logic [z80_dp_pkg::addr_src_w-1:0]  addr_src,
  input  logic                               ld_mdr1,
  input  logic                               ld_mdr2,
  input  logic                               ld_temp,
  input  logic                               ld_marh,
  input  logic                               ld_marl,
  output logic [z80_dp_pkg::byte_w-1:0]      data_out,
  output logic                               data_oe,
  output logic [z80_dp_pkg::word_w-1:0]      addr_out,
  output logic                               addr_oe
);
  import z80_dp_pkg::*;

  // --------------------------------------------------
  // internal buses and register outputs
  // --------------------------------------------------
  logic [byte_w-1:0] int_data;
  logic [word_w-1:0] int_addr;
  reg_pair_u         addr_word;

  logic [byte_w-1:0] reg_byte;
  logic [word_w-1:0] reg_pair;
  logic [byte_w-1:0] a_q;
  logic [byte_w-1:0] f_q;
  logic [byte_w-1:0] mdr1_q;
  logic [byte_w-1:0] mdr2_q;
  logic [byte_w-1:0] temp_q;
  reg_pair_u         mar_q;

  logic [byte_w-1:0] alu8_c;
  logic [byte_w-1:0] alu8_f;
  logic [word_w-1:0] alu16_c;
  logic [word_w-1:0] alu16_b;
  logic [byte_w-1:0] alu16_f;

  z80_regfile regfile_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .data_bus       (int_data),
    .addr_bus       (int_addr),
    .reg_ld         (reg_ld),
    .switch_context (switch_context),
    .reg_sel        (reg_sel),
    .pair_sel       (pair_sel),
    .reg_byte       (reg_byte),
    .reg_pair       (reg_pair)
  );

  z80_acc_flags acc_flags_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .data_bus    (int_data),
    .ld_a        (ld_a),
    .ld_f_alu8   (ld_f_alu8),
    .ld_f_alu16  (ld_f_alu16),
    .flags_alu8  (alu8_f),
    .flags_alu16 (alu16_f),
    .set_s       (set_s),
    .set_z       (set_z),
    .set_h       (set_h),
    .set_pv      (set_pv),
    .set_n       (set_n),
    .set_c       (set_c),
    .a_q         (a_q),
    .f_q         (f_q)
  );

  // --------------------------------------------------
  // alus, both on the same op code
  // --------------------------------------------------
  // a against the raw external byte
  z80_alu #(.width(byte_w)) alu8_i (
    .a     (a_q),
    .b     (data_in),
    .op    (alu_op),
    .f_in  (f_q),
    .c     (alu8_c),
    .f_out (alu8_f)
  );

  // temp zero extended, sign handled inside by op_add_se_b
  assign alu16_b = {{(word_w - byte_w){1'b0}}, temp_q};

  z80_alu #(.width(word_w)) alu16_i (
    .a     (reg_pair),
    .b     (alu16_b),
    .op    (alu_op),
    .f_in  (f_q),
    .c     (alu16_c),
    .f_out (alu16_f)
  );

  // --------------------------------------------------
  // temp, mdr and mar
  // --------------------------------------------------
  assign addr_word.word = int_addr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mdr1_q     <= '0;
      mdr2_q     <= '0;
      temp_q     <= '0;
      mar_q.word <= '0;
    end else begin
      if (ld_mdr1) begin
        mdr1_q <= int_data;
      end
      if (ld_mdr2) begin
        mdr2_q <= int_data;
      end
      if (ld_temp) begin
        temp_q <= int_data;
      end
      // mar halves load on their own
      if (ld_marh) begin
        mar_q.bytes.hi <= addr_word.bytes.hi;
      end
      if (ld_marl) begin
        mar_q.bytes.lo <= addr_word.bytes.lo;
      end
    end
  end

  // --------------------------------------------------
  // bus arbitration
  // --------------------------------------------------
  always_comb begin
    case (data_src)
      src_reg:  int_data = reg_byte;
      src_a:    int_data = a_q;
      src_f:    int_data = f_q;
      src_temp: int_data = temp_q;
      src_mdr1: int_data = mdr1_q;
      src_mdr2: int_data = mdr2_q;
      src_alu8: int_data = alu8_c;
      // src_none, bus follows the external input
      default:  int_data = data_in;
    endcase
  end

  always_comb begin
    case (addr_src)
      asrc_mar:   int_addr = mar_q.word;
      asrc_alu16: int_addr = alu16_c;
      default:    int_addr = '0;
    endcase
  end

  assign data_out = int_data;
  assign data_oe  = (data_src != src_none);
  assign addr_out = int_addr;
  assign addr_oe  = (addr_src != asrc_none);

endmodule

`default_nettype wire

// ==== tb/z80_datapath_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_datapath_sva (
  input wire                              clk,
  input wire                              arst_n,
  input wire [z80_dp_pkg::data_src_w-1:0] data_src,
  input wire [z80_dp_pkg::addr_src_w-1:0] addr_src,
  input wire                              data_oe,
  input wire [z80_dp_pkg::word_w-1:0]     addr_out,
  input wire                              addr_oe
);
  import z80_dp_pkg::*;

  // running count of assertion failures
  int fails = 0;

  // data bus driven for every source but none
  a_data_oe: assert property (@(posedge clk) data_oe == (data_src != src_none))
    else begin
      fails++;
      $error("data_oe does not follow data_src");
    end

  a_addr_oe: assert property (@(posedge clk) addr_oe == (addr_src != asrc_none))
    else begin
      fails++;
      $error("addr_oe does not follow addr_src");
    end

  // undriven address bus reads zero
  a_addr_idle: assert property (@(posedge clk) !addr_oe |-> addr_out == '0)
    else begin
      fails++;
      $error("addr_out is nonzero while not driven");
    end

  // mar is cleared while reset is held
  a_reset_mar: assert property (@(posedge clk)
                                (!arst_n && addr_src == asrc_mar) |-> addr_out == '0)
    else begin
      fails++;
      $error("mar is nonzero during reset");
    end

endmodule

bind z80_datapath z80_datapath_sva sva_i (.*);

`default_nettype wire

// ==== tb/z80_datapath_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_datapath_checker (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire [z80_dp_pkg::byte_w-1:0]      data_in,
  input  wire [z80_dp_pkg::num_regs-1:0]    reg_ld,
  input  wire [z80_dp_pkg::reg_idx_w-1:0]   reg_sel,
  input  wire [z80_dp_pkg::pair_w-1:0]      pair_sel,
  input  wire                               switch_context,
  input  wire                               ld_a, ld_f_alu8, ld_f_alu16,
  input  wire [z80_alu_pkg::flag_ctl_w-1:0] set_s, set_z, set_h, set_pv, set_n, set_c,
  input  wire [z80_alu_pkg::alu_op_w-1:0]   alu_op,
  input  wire [z80_dp_pkg::data_src_w-1:0]  data_src,
  input  wire [z80_dp_pkg::addr_src_w-1:0]  addr_src,
  input  wire                               ld_mdr1, ld_mdr2, ld_temp, ld_marh, ld_marl,
  input  wire [z80_dp_pkg::byte_w-1:0]      data_out,
  input  wire                               data_oe,
  input  wire [z80_dp_pkg::word_w-1:0]      addr_out,
  input  wire                               addr_oe,
  output int                                errors,
  output int                                checks
);
  import z80_dp_pkg::*;
  import z80_alu_pkg::*;

  // --------------------------------------------------
  // model state
  // --------------------------------------------------
  logic [byte_w-1:0] regs   [num_regs];
  logic [byte_w-1:0] shadow [num_ctx_regs];
  logic [byte_w-1:0] a_m, f_m, temp_m, mdr1_m, mdr2_m;
  logic [word_w-1:0] mar_m;

  initial begin
    errors = 0;
    checks = 0;
  end

  // narrow results keep only the low byte
  function automatic logic [word_w-1:0] alu_ref(input logic [word_w-1:0] a, b,
                                                input logic [alu_op_w-1:0] op,
                                                input logic wide);
    logic [word_w-1:0] r;
    case (op)
      op_incr_a:   r = a + 16'd1;
      op_decr_a:   r = a - 16'd1;
      op_add:      r = a + b;
      op_pass_b:   r = b;
      op_add_se_b: r = a + {{8{b[7]}}, b[7:0]};
      default:     r = a;
    endcase
    return wide ? r : {8'h00, r[7:0]};
  endfunction

  function automatic logic [byte_w-1:0] flags_ref(input logic [byte_w-1:0] f,
                                                  input logic [alu_op_w-1:0] op,
                                                  input logic [word_w-1:0] r);
    logic [byte_w-1:0] fo;
    fo = f;
    if (op == op_decr_a) begin
      fo[flag_pv] = (r != '0);
    end
    return fo;
  endfunction

  function automatic logic forced_bit(input logic cur, input logic [flag_ctl_w-1:0] code);
    if (code == flag_set) begin
      return 1'b1;
    end
    if (code == flag_clr) begin
      return 1'b0;
    end
    return cur;
  endfunction

  function automatic logic [byte_w-1:0] byte_read();
    return (reg_sel < num_regs) ? regs[reg_sel] : '0;
  endfunction

  function automatic logic [word_w-1:0] pair_read();
    if (pair_sel <= pair_pc) begin
      return {regs[2*pair_sel], regs[2*pair_sel+1]};
    end
    return '0;
  endfunction

  // expected {data_out, data_oe, addr_out, addr_oe} from the model
  function automatic logic [byte_w+word_w+1:0] expected_bus();
    logic [byte_w-1:0] d;
    logic [word_w-1:0] ad;
    case (data_src)
      src_reg:  d = byte_read();
      src_a:    d = a_m;
      src_f:    d = f_m;
      src_temp: d = temp_m;
      src_mdr1: d = mdr1_m;
      src_mdr2: d = mdr2_m;
      src_alu8: d = byte_w'(alu_ref({8'h00, a_m}, {8'h00, data_in}, alu_op, 1'b0));
      default:  d = data_in;
    endcase
    case (addr_src)
      asrc_mar:   ad = mar_m;
      asrc_alu16: ad = alu_ref(pair_read(), {8'h00, temp_m}, alu_op, 1'b1);
      default:    ad = '0;
    endcase
    return {d, data_src != src_none, ad, addr_src != asrc_none};
  endfunction

  task automatic compare_value(input string name, input logic [word_w-1:0] exp_v, act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
    end
  endtask

  // --------------------------------------------------
  // compare mid cycle, then step the model to the next edge
  // --------------------------------------------------
  always @(negedge clk) begin
    logic [byte_w-1:0] d_exp;
    logic              doe_exp;
    logic [word_w-1:0] a_exp;
    logic              aoe_exp;
    logic [word_w-1:0] r8;
    logic [word_w-1:0] r16;
    logic [byte_w-1:0] f_next;
    logic [byte_w-1:0] t;
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < num_ctx_regs; i++) begin
        shadow[i] = '0;
      end
      {a_m, f_m, temp_m, mdr1_m, mdr2_m, mar_m} = '0;
    end
    {d_exp, doe_exp, a_exp, aoe_exp} = expected_bus();
    compare_value("data_out", d_exp, data_out);
    compare_value("data_oe", doe_exp, data_oe);
    compare_value("addr_out", a_exp, addr_out);
    compare_value("addr_oe", aoe_exp, addr_oe);
    if (arst_n) begin
      // alu results come from the state before the edge
      r8     = alu_ref({8'h00, a_m}, {8'h00, data_in}, alu_op, 1'b0);
      r16    = alu_ref(pair_read(), {8'h00, temp_m}, alu_op, 1'b1);
      f_next = ld_f_alu8 ? flags_ref(f_m, alu_op, r8) :
               (ld_f_alu16 ? flags_ref(f_m, alu_op, r16) : f_m);
      f_next[flag_s]  = forced_bit(f_next[flag_s], set_s);
      f_next[flag_z]  = forced_bit(f_next[flag_z], set_z);
      f_next[flag_h]  = forced_bit(f_next[flag_h], set_h);
      f_next[flag_pv] = forced_bit(f_next[flag_pv], set_pv);
      f_next[flag_n]  = forced_bit(f_next[flag_n], set_n);
      f_next[flag_c]  = forced_bit(f_next[flag_c], set_c);
      f_m = f_next;
      if (switch_context) begin
        for (int i = 0; i < num_ctx_regs; i++) begin
          if (reg_ld[i]) begin
            t         = regs[i];
            regs[i]   = shadow[i];
            shadow[i] = t;
          end
        end
      end else begin
        for (int p = 0; p < num_regs / 2; p++) begin
          if (reg_ld[2*p] && reg_ld[2*p+1]) begin
            regs[2*p]   = a_exp[15:8];
            regs[2*p+1] = a_exp[7:0];
          end else begin
            if (reg_ld[2*p]) begin
              regs[2*p] = d_exp;
            end
            if (reg_ld[2*p+1]) begin
              regs[2*p+1] = d_exp;
            end
          end
        end
      end
      if (ld_a) a_m = d_exp;
      if (ld_temp) temp_m = d_exp;
      if (ld_mdr1) mdr1_m = d_exp;
      if (ld_mdr2) mdr2_m = d_exp;
      if (ld_marh) mar_m[15:8] = a_exp[15:8];
      if (ld_marl) mar_m[7:0] = a_exp[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== tb/z80_datapath_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module z80_datapath_tb;
  import z80_dp_pkg::*;
  import z80_alu_pkg::*;

  localparam int max_cycles  = 5000;
  localparam int rand_cycles = 500;

  // --------------------------------------------------
  // dut signals
  // --------------------------------------------------
  logic                  clk;
  logic                  arst_n;
  logic [byte_w-1:0]     data_in;
  logic [num_regs-1:0]   reg_ld;
  logic [reg_idx_w-1:0]  reg_sel;
  logic [pair_w-1:0]     pair_sel;
  logic                  switch_context;
  logic                  ld_a, ld_f_alu8, ld_f_alu16;
  logic [flag_ctl_w-1:0] set_s, set_z, set_h, set_pv, set_n, set_c;
  logic [alu_op_w-1:0]   alu_op;
  logic [data_src_w-1:0] data_src;
  logic [addr_src_w-1:0] addr_src;
  logic                  ld_mdr1, ld_mdr2, ld_temp, ld_marh, ld_marl;
  logic [byte_w-1:0]     data_out;
  logic                  data_oe;
  logic [word_w-1:0]     addr_out;
  logic                  addr_oe;

  // counts from the checker
  int          errors;
  int          checks;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q    = 32'h17558f9a;

  z80_datapath dut_i (.*);

  z80_datapath_checker checker_i (.*);

  always #5 clk = ~clk;

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // wait for the edge, then drop every input back to idle
  task automatic start_cycle();
    @(posedge clk);
    data_in  <= '0;
    reg_ld   <= '0;
    reg_sel  <= '0;
    pair_sel <= '0;
    alu_op   <= op_pass_a;
    data_src <= src_none;
    addr_src <= asrc_none;
    {switch_context, ld_a, ld_f_alu8, ld_f_alu16} <= '0;
    {set_s, set_z, set_h, set_pv, set_n, set_c} <= '0;
    {ld_mdr1, ld_mdr2, ld_temp, ld_marh, ld_marl} <= '0;
  endtask

  task automatic run_idle(input int n);
    for (int i = 0; i < n; i++) begin
      start_cycle();
    end
  endtask

  task automatic read_byte(input int idx);
    start_cycle();
    data_src <= src_reg;
    reg_sel  <= reg_idx_w'(idx);
  endtask

  // k picks a, temp, mdr1 or mdr2
  task automatic load_and_read(input int k);
    start_cycle();
    data_in <= byte_w'(rand_bits(8));
    case (k)
      0:       ld_a    <= 1'b1;
      1:       ld_temp <= 1'b1;
      2:       ld_mdr1 <= 1'b1;
      default: ld_mdr2 <= 1'b1;
    endcase
    start_cycle();
    case (k)
      0:       data_src <= src_a;
      1:       data_src <= src_temp;
      2:       data_src <= src_mdr1;
      default: data_src <= src_mdr2;
    endcase
  endtask

  // result back into a with flags, then read a and f
  task automatic alu8_op(input logic [alu_op_w-1:0] op, input logic [byte_w-1:0] b);
    start_cycle();
    data_in   <= b;
    alu_op    <= op;
    data_src  <= src_alu8;
    ld_a      <= 1'b1;
    ld_f_alu8 <= 1'b1;
    start_cycle();
    data_src <= src_a;
    start_cycle();
    data_src <= src_f;
  endtask

  // k counts flag codes from c upward, both alu loads compete
  task automatic flag_override(input int k, input logic [flag_ctl_w-1:0] code);
    start_cycle();
    alu_op     <= op_decr_a;
    ld_f_alu8  <= k[0];
    ld_f_alu16 <= 1'b1;
    {set_s, set_z, set_h, set_pv, set_n, set_c} <= (12'(code) << (2 * k));
    start_cycle();
    data_src <= src_f;
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("timeout, stimulus did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    data_in  = '0;
    reg_ld   = '0;
    reg_sel  = '0;
    pair_sel = '0;
    alu_op   = op_pass_a;
    data_src = src_none;
    addr_src = asrc_none;
    {switch_context, ld_a, ld_f_alu8, ld_f_alu16} = '0;
    {set_s, set_z, set_h, set_pv, set_n, set_c} = '0;
    {ld_mdr1, ld_mdr2, ld_temp, ld_marh, ld_marl} = '0;

    // mar drives the address bus while reset is held
    for (int i = 0; i < 10; i++) begin
      start_cycle();
      addr_src <= asrc_mar;
    end
    arst_n <= 1'b1;

    // everything reads zero after reset
    for (int i = 0; i < num_regs; i++) begin
      read_byte(i);
    end
    for (int s = src_a; s <= src_mdr2; s++) begin
      start_cycle();
      data_src <= data_src_w'(s);
      addr_src <= asrc_mar;
    end

    // byte loads off data_in
    for (int i = 0; i < num_regs; i++) begin
      start_cycle();
      data_in <= byte_w'(rand_bits(8));
      reg_ld  <= num_regs'(1) << i;
      read_byte(i);
    end
    for (int k = 0; k < 4; k++) begin
      load_and_read(k);
    end

    // trade b d e l with the shadows and back, c h stay
    for (int n = 0; n < 2; n++) begin
      start_cycle();
      switch_context <= 1'b1;
      reg_ld         <= 12'h02d;
      for (int i = 0; i < num_ctx_regs; i++) begin
        read_byte(i);
      end
    end

    // 8 bit alu, then decrement through zero
    for (int op = op_incr_a; op <= op_add_se_b; op++) begin
      alu8_op(alu_op_w'(op), byte_w'(rand_bits(8)));
    end
    start_cycle();
    data_in <= 8'h01;
    ld_a    <= 1'b1;
    alu8_op(op_decr_a, 8'h00);
    alu8_op(op_decr_a, 8'h00);

    // 16 bit alu into each pair
    start_cycle();
    data_in <= byte_w'(rand_bits(8));
    ld_temp <= 1'b1;
    for (int p = 0; p <= pair_pc; p++) begin
      for (int op = op_incr_a; op <= op_add_se_b; op++) begin
        start_cycle();
        pair_sel <= pair_w'(p);
        alu_op   <= alu_op_w'(op);
        addr_src <= asrc_alu16;
        reg_ld   <= num_regs'(3) << (2 * p);
        start_cycle();
        pair_sel <= pair_w'(p);
        addr_src <= asrc_alu16;
      end
      read_byte(2 * p);
      read_byte(2 * p + 1);
    end

    // mar by high byte, low byte and both, negative offset in temp
    start_cycle();
    data_in <= byte_w'(rand_bits(8)) | 8'h80;
    ld_temp <= 1'b1;
    for (int m = 1; m < 4; m++) begin
      start_cycle();
      pair_sel <= pair_w'(rand_bits(3));
      alu_op   <= op_add_se_b;
      addr_src <= asrc_alu16;
      {ld_marh, ld_marl} <= 2'(m);
      start_cycle();
      addr_src <= asrc_mar;
    end

    for (int k = 0; k < 6; k++) begin
      flag_override(k, flag_set);
      flag_override(k, flag_clr);
    end

    // random traffic on every input
    for (int n = 0; n < rand_cycles; n++) begin
      start_cycle();
      data_in        <= byte_w'(rand_bits(8));
      reg_ld         <= num_regs'(rand_bits(12));
      reg_sel        <= reg_idx_w'(rand_bits(4));
      pair_sel       <= pair_w'(rand_bits(3));
      switch_context <= (rand_bits(3) == 32'd0);
      {ld_a, ld_f_alu8, ld_f_alu16} <= 3'(rand_bits(3));
      {set_s, set_z, set_h, set_pv, set_n, set_c} <= 12'(rand_bits(12));
      alu_op         <= alu_op_w'(rand_bits(4));
      data_src       <= data_src_w'(rand_bits(3));
      addr_src       <= addr_src_w'(rand_bits(2));
      {ld_mdr1, ld_mdr2, ld_temp, ld_marh, ld_marl} <= 5'(rand_bits(5));
    end

    run_idle(3);
    if (checks == 0) begin
      $display("no bus outputs were compared");
    end
    $display("%0d checks, %0d mismatches, %0d assertion failures",
             checks, errors, dut_i.sva_i.fails);
    if (errors == 0 && checks > 0 && dut_i.sva_i.fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/z80_dp_pkg.sv
rtl/z80_alu_pkg.sv
rtl/z80_regfile.sv
rtl/z80_alu.sv
rtl/z80_acc_flags.sv
rtl/z80_datapath.sv
tb/z80_datapath_sva.sv
tb/z80_datapath_checker.sv
tb/z80_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: z80_datapath

sources:
  - files:
      - rtl/z80_dp_pkg.sv
      - rtl/z80_alu_pkg.sv
      - rtl/z80_regfile.sv
      - rtl/z80_alu.sv
      - rtl/z80_acc_flags.sv
      - rtl/z80_datapath.sv
  - target: test
    files:
      - tb/z80_datapath_sva.sv
      - tb/z80_datapath_checker.sv
      - tb/z80_datapath_tb.sv
